// File: Makefile
TOP = tb_riscv_core

.PHONY: all lint clean

all:
	verilator --binary --timing -f all.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: all.f
+incdir+test
common/rv_pkg.sv
src/fetch_unit.sv
decode/instr_decoder.sv
decode/reg_file.sv
src/alu.sv
src/forwarding_unit.sv
src/data_memory.sv
src/riscv_core.sv
test/tb_riscv_core.sv

// File: common/rv_pkg.sv
// rv32i pipeline shared definitions
// widths, decoded opcode and alu enums, stage register structs

package rv_pkg;

    localparam int xlen       = 32;            // data and address width
    localparam int reg_addr_w = 5;             // 32 architectural registers

    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;  // addi x0, x0, 0

    // decoded operations
    typedef enum logic [3:0] {
        op_add, op_sub, op_and, op_or, op_slt,
        op_addi, op_lw, op_sw, op_beq, op_jal,
        op_halt, op_nop
    } op_e;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt} alu_op_e;

    typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_sel_e;  // writeback source

    // program load port, word indexed
    typedef struct packed {
        logic            en;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
    } imem_load_t;

    // ============================================================
    // stage registers
    // ============================================================

    typedef struct packed {
        logic [xlen-1:0] instr;
        logic [xlen-1:0] pc;
    } fd_t;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;  // operand b from immediate
        logic    branch;
        logic    jump;
        logic    mem_wr;
        wb_sel_e wb_sel;
        logic    rf_wr;
        logic    halt;     // ecall marker, rides down to writeback
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       pc;
        ctrl_t                 ctrl;
    } de_t;

    typedef struct packed {
        logic [xlen-1:0]       alu_res;
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       pc_plus_4;
        logic                  mem_wr;
        wb_sel_e               wb_sel;
        logic                  rf_wr;
        logic                  halt;
    } em_t;

    typedef struct packed {
        logic [xlen-1:0]       alu_res;
        logic [xlen-1:0]       mem_data;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       pc_plus_4;
        wb_sel_e               wb_sel;
        logic                  rf_wr;
        logic                  halt;
    } mw_t;

    // one entry per register write at writeback
    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } retire_t;

endpackage

// File: decode/instr_decoder.sv
// instruction decoder
// rv32i subset to op enum, control struct, register fields and immediate

module instr_decoder (
    input  logic [rv_pkg::xlen-1:0]       instr,
    input  logic [rv_pkg::xlen-1:0]       pc,
    output logic [rv_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_pkg::reg_addr_w-1:0] rd,
    output logic [rv_pkg::xlen-1:0]       imm,
    output rv_pkg::op_e                   op,
    output rv_pkg::ctrl_t                 ctrl
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [rv_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];   // unused by sw/beq since rf_wr stays low

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // opcode and funct decode, anything unrecognised is a bubble
    always_comb begin
        op = rv_pkg::op_nop;
        if (pc[1:0] == 2'b00 && instr != rv_pkg::nop_instr) begin  // misaligned fetch never issues
            case (opcode)
                7'b0110011: begin
                    if (funct7 == 7'b0000000) begin
                        case (funct3)
                            3'b000:  op = rv_pkg::op_add;
                            3'b111:  op = rv_pkg::op_and;
                            3'b110:  op = rv_pkg::op_or;
                            3'b010:  op = rv_pkg::op_slt;
                            default: op = rv_pkg::op_nop;
                        endcase
                    end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                        op = rv_pkg::op_sub;
                    end
                end
                7'b0010011: if (funct3 == 3'b000) op = rv_pkg::op_addi;
                7'b0000011: if (funct3 == 3'b010) op = rv_pkg::op_lw;
                7'b0100011: if (funct3 == 3'b010) op = rv_pkg::op_sw;
                7'b1100011: if (funct3 == 3'b000) op = rv_pkg::op_beq;
                7'b1101111: op = rv_pkg::op_jal;
                7'b1110011: if (instr[31:7] == '0) op = rv_pkg::op_halt;  // ecall only
                default:    op = rv_pkg::op_nop;
            endcase
        end
    end

    // control fields per op
    always_comb begin
        ctrl = '0;     // alu_add, wb_alu, nothing written
        imm  = imm_i;
        case (op)
            rv_pkg::op_sub: ctrl.alu_op = rv_pkg::alu_sub;
            rv_pkg::op_and: ctrl.alu_op = rv_pkg::alu_and;
            rv_pkg::op_or:  ctrl.alu_op = rv_pkg::alu_or;
            rv_pkg::op_slt: ctrl.alu_op = rv_pkg::alu_slt;
            default:        ctrl.alu_op = rv_pkg::alu_add;
        endcase
        case (op)
            rv_pkg::op_add, rv_pkg::op_sub, rv_pkg::op_and,
            rv_pkg::op_or, rv_pkg::op_slt: ctrl.rf_wr = 1'b1;
            rv_pkg::op_addi: begin
                ctrl.use_imm = 1'b1;
                ctrl.rf_wr   = 1'b1;
            end
            rv_pkg::op_lw: begin
                ctrl.use_imm = 1'b1;  // address = rs1 + imm_i
                ctrl.wb_sel  = rv_pkg::wb_mem;
                ctrl.rf_wr   = 1'b1;
            end
            rv_pkg::op_sw: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_wr  = 1'b1;
                imm          = imm_s;
            end
            rv_pkg::op_beq: begin
                ctrl.branch = 1'b1;   // compares rs1 and rs2 through the alu equal flag
                imm         = imm_b;
            end
            rv_pkg::op_jal: begin
                ctrl.jump   = 1'b1;   // target formed in execute
                ctrl.wb_sel = rv_pkg::wb_link;
                ctrl.rf_wr  = 1'b1;
                imm         = imm_j;
            end
            rv_pkg::op_halt: ctrl.halt = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: decode/reg_file.sv
// register file
// 31 writable registers, x0 reads zero, writeback bypassed to same-cycle reads

module reg_file (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_pkg::xlen-1:0]       rs1_data,
    output logic [rv_pkg::xlen-1:0]       rs2_data,
    input  logic                          wr_en,
    input  logic [rv_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [rv_pkg::xlen-1:0]       wr_data
);

    logic [rv_pkg::xlen-1:0] regs [1:31];  // no storage for x0

    function automatic logic [rv_pkg::xlen-1:0] read_port(
        input logic [rv_pkg::reg_addr_w-1:0] addr
    );
        if (addr == '0) return '0;
        if (wr_en && addr == wr_addr) return wr_data;  // write in flight this cycle
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// File: src/alu.sv
// execute stage alu
// add, sub, and, or, signed slt, plus the equality flag used by beq

module alu (
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    input  rv_pkg::alu_op_e         alu_op,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    equal
);

    logic lt;  // signed compare

    assign lt    = $signed(a) < $signed(b);
    assign equal = (a == b);  // beq keeps use_imm low so b is rs2

    always_comb begin
        case (alu_op)
            rv_pkg::alu_add: result = a + b;
            rv_pkg::alu_sub: result = a - b;
            rv_pkg::alu_and: result = a & b;
            rv_pkg::alu_or:  result = a | b;
            rv_pkg::alu_slt: result = {{(rv_pkg::xlen-1){1'b0}}, lt};
            default:         result = a + b;
        endcase
    end

endmodule

// File: src/data_memory.sv
// data memory
// word array, combinational read, write on the clock edge of the memory stage

module data_memory #(
    parameter int dmem_depth = 256
) (
    input  logic                    clk,
    input  logic [rv_pkg::xlen-1:0] addr,     // byte address
    input  logic                    wr_en,
    input  logic [rv_pkg::xlen-1:0] wr_data,
    output logic [rv_pkg::xlen-1:0] rd_data
);

    localparam int aw = $clog2(dmem_depth);

    logic [rv_pkg::xlen-1:0] mem [dmem_depth];
    logic [aw-1:0]           idx;

    assign idx     = addr[aw+1:2];  // word select, low bits dropped
    assign rd_data = mem[idx];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[idx] <= wr_data;
        end
    end

endmodule

// File: src/fetch_unit.sv
// fetch stage
// program counter, instruction rom with reset-time load port, fd register

module fetch_unit #(
    parameter int imem_depth = 512
) (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_pkg::imem_load_t      imem_load,
    input  logic                    redirect,  // taken branch or jump from execute
    input  logic [rv_pkg::xlen-1:0] target,
    input  logic                    hold,      // halt seen in decode
    input  logic                    flush,
    output rv_pkg::fd_t             fd
);

    localparam int aw = $clog2(imem_depth);

    logic [rv_pkg::xlen-1:0] imem [imem_depth];
    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] instr;
    logic                    halted;  // sticky, pc frozen until rst

    // testbench writes the program while the core sits in reset
    always_ff @(posedge clk) begin
        if (rst && imem_load.en) begin
            imem[imem_load.addr[aw-1:0]] <= imem_load.data;
        end
    end

    assign instr = imem[pc[aw+1:2]];  // async rom read, word index

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            if (hold) halted <= 1'b1;
            if (redirect) pc <= target;                        // branch wins
            else if (!(hold || halted)) pc <= pc + 32'd4;
        end
    end

    // fd register, bubble on reset and on flush
    always_ff @(posedge clk) begin
        if (rst) begin
            fd <= '{instr: rv_pkg::nop_instr, pc: '0};
        end else begin
            fd.instr <= flush ? rv_pkg::nop_instr : instr;
            fd.pc    <= pc;
        end
    end

endmodule

// File: src/forwarding_unit.sv
// execute operand forwarding and branch resolution
// memory stage beats writeback, taken branch or jump redirects fetch

module forwarding_unit (
    input  rv_pkg::de_t             de,
    input  rv_pkg::em_t             em,
    input  logic [rv_pkg::xlen-1:0] mem_data,   // async dmem read of the memory stage
    input  logic [rv_pkg::xlen-1:0] wb_data,
    input  rv_pkg::mw_t             mw,
    input  logic                    equal,
    output logic [rv_pkg::xlen-1:0] op_a,
    output logic [rv_pkg::xlen-1:0] op_b,
    output logic [rv_pkg::xlen-1:0] store_data,
    output logic                    redirect,
    output logic [rv_pkg::xlen-1:0] target,
    output logic                    flush
);

    logic [rv_pkg::xlen-1:0] mem_fwd;  // value the memory stage will write back
    logic [rv_pkg::xlen-1:0] rs1_fwd, rs2_fwd;

    always_comb begin
        case (em.wb_sel)
            rv_pkg::wb_mem:  mem_fwd = mem_data;     // load result forwarded to next instr
            rv_pkg::wb_link: mem_fwd = em.pc_plus_4;
            default:         mem_fwd = em.alu_res;
        endcase
    end

    function automatic logic [rv_pkg::xlen-1:0] pick(
        input logic [rv_pkg::reg_addr_w-1:0] rs,
        input logic [rv_pkg::xlen-1:0]       rf_data
    );
        if (em.rf_wr && em.rd != '0 && em.rd == rs) return mem_fwd;  // youngest first
        if (mw.rf_wr && mw.rd != '0 && mw.rd == rs) return wb_data;
        return rf_data;
    endfunction

    always_comb begin
        rs1_fwd = pick(de.rs1, de.rs1_data);
        rs2_fwd = pick(de.rs2, de.rs2_data);
    end

    assign op_a       = rs1_fwd;
    assign op_b       = de.ctrl.use_imm ? de.imm : rs2_fwd;
    assign store_data = rs2_fwd;

    // ============================================================
    // branch and jump resolution
    // ============================================================
    assign redirect = (de.ctrl.branch && equal) || de.ctrl.jump;
    assign target   = de.pc + de.imm;  // beq and jal are both pc relative
    assign flush    = redirect;        // kills fetch and decode slots

endmodule

// File: src/riscv_core.sv
// five stage rv32i core
// fetch, decode, execute, memory, writeback with forwarding and flush on redirect
// retire reports each register write, ohalt goes sticky once ecall hits writeback

module riscv_core #(
    parameter int imem_depth = 512,
    parameter int dmem_depth = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  rv_pkg::imem_load_t imem_load,  // honored only during reset
    output rv_pkg::retire_t    retire,
    output logic               ohalt
);

    rv_pkg::fd_t fd;
    rv_pkg::de_t de_d, de;
    rv_pkg::em_t em_d, em;
    rv_pkg::mw_t mw_d, mw;

    logic [rv_pkg::reg_addr_w-1:0] dec_rs1, dec_rs2, dec_rd;
    logic [rv_pkg::xlen-1:0]       dec_imm, rs1_data, rs2_data;
    rv_pkg::op_e                   dec_op;
    rv_pkg::ctrl_t                 dec_ctrl;

    logic [rv_pkg::xlen-1:0] op_a, op_b, store_data, alu_res, target, mem_data, wb_data;
    logic equal, redirect, flush;
    logic hold;         // ecall sitting in decode
    logic halt_behind;  // ecall already past decode
    logic dec_kill;     // decode slot becomes a bubble
    logic ohalt_q;

    assign halt_behind = de.ctrl.halt || em.halt || mw.halt || ohalt_q;
    assign dec_kill    = flush || halt_behind;
    assign hold        = (dec_op == rv_pkg::op_halt) && !dec_kill;

    // ============================================================
    // fetch and decode
    // ============================================================
    fetch_unit #(.imem_depth(imem_depth)) u_fetch (
        .clk(clk), .rst(rst), .imem_load(imem_load), .redirect(redirect),
        .target(target), .hold(hold), .flush(flush), .fd(fd)
    );

    instr_decoder u_dec (
        .instr(fd.instr), .pc(fd.pc), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
        .imm(dec_imm), .op(dec_op), .ctrl(dec_ctrl)
    );

    reg_file u_rf (
        .clk(clk), .rst(rst), .rs1(dec_rs1), .rs2(dec_rs2), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .wr_en(mw.rf_wr), .wr_addr(mw.rd), .wr_data(wb_data)
    );

    assign de_d = '{rs1_data: rs1_data, rs2_data: rs2_data, imm: dec_imm, rs1: dec_rs1,
                    rs2: dec_rs2, rd: dec_rd, pc: fd.pc, ctrl: dec_ctrl};

    always_ff @(posedge clk) begin
        if (rst || dec_kill) de <= '0;  // cleared ctrl is a bubble
        else de <= de_d;
    end

    // ============================================================
    // execute
    // ============================================================
    forwarding_unit u_fwd (
        .de(de), .em(em), .mem_data(mem_data), .wb_data(wb_data), .mw(mw),
        .equal(equal), .op_a(op_a), .op_b(op_b), .store_data(store_data),
        .redirect(redirect), .target(target), .flush(flush)
    );

    alu u_alu (.a(op_a), .b(op_b), .alu_op(de.ctrl.alu_op), .result(alu_res), .equal(equal));

    assign em_d = '{alu_res: alu_res, store_data: store_data, rd: de.rd,
                    pc_plus_4: de.pc + 32'd4, mem_wr: de.ctrl.mem_wr,
                    wb_sel: de.ctrl.wb_sel, rf_wr: de.ctrl.rf_wr, halt: de.ctrl.halt};

    always_ff @(posedge clk) begin
        if (rst) em <= '0;
        else em <= em_d;
    end

    // ============================================================
    // memory and writeback
    // ============================================================
    data_memory #(.dmem_depth(dmem_depth)) u_dmem (
        .clk(clk), .addr(em.alu_res), .wr_en(em.mem_wr), .wr_data(em.store_data),
        .rd_data(mem_data)
    );

    assign mw_d = '{alu_res: em.alu_res, mem_data: mem_data, rd: em.rd,
                    pc_plus_4: em.pc_plus_4, wb_sel: em.wb_sel, rf_wr: em.rf_wr,
                    halt: em.halt};

    always_ff @(posedge clk) begin
        if (rst) mw <= '0;
        else mw <= mw_d;
    end

    always_comb begin
        case (mw.wb_sel)
            rv_pkg::wb_mem:  wb_data = mw.mem_data;
            rv_pkg::wb_link: wb_data = mw.pc_plus_4;  // jal link value
            default:         wb_data = mw.alu_res;
        endcase
    end

    assign retire = '{valid: mw.rf_wr && (mw.rd != '0), rd: mw.rd, data: wb_data};

    always_ff @(posedge clk) begin
        if (rst) ohalt_q <= 1'b0;
        else if (mw.halt) ohalt_q <= 1'b1;  // holds until next reset
    end

    assign ohalt = ohalt_q || mw.halt;  // up in the cycle ecall reaches writeback

endmodule

// File: test/tb_program.svh
// test program for the rv32i core and the register writes it should retire
// words are loaded at index 0 upwards while the core sits in reset

`ifndef tb_program_svh
`define tb_program_svh

localparam int prog_len = 16;

localparam logic [31:0] prog_words [prog_len] = '{
    32'h00c0_0093,  //  0  addi x1, x0, 12
    32'h0010_8133,  //  1  add  x2, x1, x1      back to back
    32'h4020_81b3,  //  2  sub  x3, x1, x2      x1 two back, writeback path
    32'h0011_f233,  //  3  and  x4, x3, x1      x1 three back, rf bypass
    32'h0022_62b3,  //  4  or   x5, x4, x2
    32'h0051_a333,  //  5  slt  x6, x3, x5      signed, -12 < 28
    32'h0050_2423,  //  6  sw   x5, 8(x0)
    32'h0080_2383,  //  7  lw   x7, 8(x0)       reads the word just stored
    32'h0063_8433,  //  8  add  x8, x7, x6      load value straight from memory stage
    32'h0634_0013,  //  9  addi x0, x8, 99      no retirement
    32'h0005_8663,  // 10  beq  x11, x0, +12    taken first pass, not taken second
    32'h0080_04b3,  // 11  add  x9, x0, x8      runs on the second pass only
    32'h0000_0073,  // 12  ecall
    32'hff5f_f5ef,  // 13  jal  x11, -12        back to word 10, x11 = 56
    32'h0010_0613,  // 14  addi x12, x0, 1      never retires
    32'h0020_0693   // 15  addi x13, x0, 2      never retires
};

// expected retire stream in order
// columns are valid, rd, data
localparam int exp_len = 10;

localparam rv_pkg::retire_t exp_retire [exp_len] = '{
    {1'b1, 5'd1,  32'd12},
    {1'b1, 5'd2,  32'd24},
    {1'b1, 5'd3,  32'hffff_fff4},  // 12 - 24
    {1'b1, 5'd4,  32'd4},
    {1'b1, 5'd5,  32'd28},
    {1'b1, 5'd6,  32'd1},
    {1'b1, 5'd7,  32'd28},
    {1'b1, 5'd8,  32'd29},
    {1'b1, 5'd11, 32'd56},         // jal link, pc 52 plus 4
    {1'b1, 5'd9,  32'd29}
};

`endif

// File: test/tb_riscv_core.sv
// testbench for the five stage rv32i core
// loads a fixed program through the reset-time port, then checks retire and ohalt

module tb_riscv_core;

    timeunit 1ns;
    timeprecision 100ps;

    `include "tb_program.svh"

    localparam int reset_cycles     = 16;
    localparam int cycle_limit      = reset_cycles + 2 * prog_len + 40;
    localparam int post_halt_cycles = 8;  // ohalt must hold and nothing may retire

    logic               clk;
    logic               rst;
    rv_pkg::imem_load_t imem_load;
    rv_pkg::retire_t    retire;
    logic               ohalt;

    int   cycles       = 0;     // every rising edge since time zero
    int   retire_idx   = 0;     // next entry of exp_retire
    int   checks       = 0;
    int   mismatches   = 0;
    int   other_errors = 0;
    logic halt_seen    = 1'b0;

    riscv_core #(
        .imem_depth(512),
        .dmem_depth(256)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .imem_load(imem_load),
        .retire(retire),
        .ohalt(ohalt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // ============================================================
    // stimulus helpers and compares
    // ============================================================

    function automatic rv_pkg::imem_load_t load_entry(input int idx);
        rv_pkg::imem_load_t e;
        e.en   = 1'b1;
        e.addr = idx;              // word index rather than byte address
        e.data = prog_words[idx];
        return e;
    endfunction

    task automatic check_retire(input rv_pkg::retire_t got, input rv_pkg::retire_t exp);
        checks++;
        if (got.rd !== exp.rd) begin
            $display("Error at %0t ns: retire.rd = x%0d, expected x%0d", $time, got.rd, exp.rd);
            mismatches++;
        end
        if (got.data !== exp.data) begin
            $display("Error at %0t ns: retire.data = 0x%08h, expected 0x%08h",
                     $time, got.data, exp.data);
            mismatches++;
        end
    endtask

    task automatic check_halt(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t ns: ohalt = %b, expected %b", $time, got, exp);
            mismatches++;
        end
    endtask

    // outputs sampled once mid cycle
    task automatic sample_outputs();
        // ecall follows the last retiring instruction directly, so ohalt is
        // high exactly once the whole table has been seen
        check_halt(ohalt, retire_idx == exp_len);
        if (ohalt === 1'b1) halt_seen = 1'b1;
        if (retire.valid === 1'b1) begin
            if (retire_idx < exp_len) begin
                check_retire(retire, exp_retire[retire_idx]);
                retire_idx++;
            end else begin
                $display("unexpected retirement at %0t ns: x%0d written with 0x%08h",
                         $time, retire.rd, retire.data);
                other_errors++;
            end
        end else if (retire.valid !== 1'b0) begin
            $display("retire.valid is unknown at %0t ns", $time);
            other_errors++;
        end
    endtask

    // ============================================================
    // main sequence
    // ============================================================

    initial begin
        rst       = 1'b1;
        imem_load = load_entry(0);  // taken at the first edge

        // one word per cycle and en drops together with rst on the last pass
        for (int c = 1; c <= reset_cycles; c++) begin
            @(posedge clk);
            #1;
            if (c < prog_len) imem_load = load_entry(c);
            else imem_load = '0;
        end
        rst = 1'b0;

        while (!halt_seen && cycles < cycle_limit) begin
            @(negedge clk);
            sample_outputs();
        end

        if (!halt_seen) begin
            $display("timeout: ohalt still low after %0d cycles", cycles);
            other_errors++;
        end else begin
            repeat (post_halt_cycles) begin
                @(negedge clk);
                sample_outputs();
            end
        end

        if (retire_idx != exp_len) begin
            $display("only %0d of %0d expected retirements arrived", retire_idx, exp_len);
            other_errors++;
        end

        $display("checks: %0d, value errors: %0d, other errors: %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
